// File: bench/exec_cluster_checks.sv
// port-level protocol checker for the execution cluster, instantiated by the testbench on DUT ports
module exec_cluster_checks (
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch,
    input  logic            dispatch_ready,
    input  exec_pkg::tag_t  dispatch_tag,
    input  logic            commit_valid,
    input  exec_pkg::tag_t  commit_tag,
    input  exec_pkg::word_t commit_value,
    input  logic            commit_is_branch,
    output int              fails
);

    exec_pkg::tag_t next_commit;

    initial fails = 0;

    // commits must walk the tags in order
    always_ff @(posedge clk) begin
        if (!rst) begin
            next_commit <= '0;
        end else if (commit_valid) begin
            next_commit <= next_commit + 1'b1;
        end
    end

    a_reset_idle: assert property (
        @(posedge clk) !rst |=> (dispatch_ready && !commit_valid && dispatch_tag == '0)
    ) else begin
        fails++;
        $display("cluster was not idle with tag 0 after reset at %0t", $time);
    end

    a_tag_advance: assert property (
        @(posedge clk) disable iff (!rst)
        (dispatch && dispatch_ready) |=>
            dispatch_tag == exec_pkg::tag_t'($past(dispatch_tag) + 1'b1)
    ) else begin
        fails++;
        $display("mismatch at %0t: dispatch tag did not advance after an accepted dispatch", $time);
    end

    a_tag_hold: assert property (
        @(posedge clk) disable iff (!rst)
        !(dispatch && dispatch_ready) |=> $stable(dispatch_tag)
    ) else begin
        fails++;
        $display("mismatch at %0t: dispatch tag moved without an accepted dispatch", $time);
    end

    a_commit_order: assert property (
        @(posedge clk) disable iff (!rst)
        commit_valid |-> commit_tag == next_commit
    ) else begin
        fails++;
        $display("mismatch at %0t: commit tag %0d, expected %0d", $time, commit_tag, next_commit);
    end

    a_commit_known: assert property (
        @(posedge clk) disable iff (!rst)
        commit_valid |-> !$isunknown({commit_value, commit_is_branch})
    ) else begin
        fails++;
        $display("commit carried unknown bits at %0t", $time);
    end

endmodule

// File: bench/exec_cluster_tb.sv
// testbench for the execution cluster, acts as rename stage with random dispatch and a result model
module exec_cluster_tb;

    localparam int n_random = 300;
    localparam int n_burst  = 10;
    localparam int limit    = 40 * (n_random + n_burst) + 200;

    logic               clk;
    logic               rst;
    logic               pause;
    logic               dispatch;
    logic               is_branch;
    exec_pkg::op_t      op;
    exec_pkg::operand_t src_1;
    exec_pkg::operand_t src_2;
    logic               dispatch_ready;
    exec_pkg::tag_t     dispatch_tag;
    logic               commit_valid;
    exec_pkg::tag_t     commit_tag;
    exec_pkg::word_t    commit_value;
    logic               commit_is_branch;
    int                 port_fails;

    logic [31:0]        lfsr;
    exec_pkg::word_t    gold [exec_pkg::rob_depth];
    logic               gbr [exec_pkg::rob_depth];
    logic               done_model [exec_pkg::rob_depth];
    exec_pkg::tag_t     head_tag;
    exec_pkg::tag_t     tail_tag;
    int                 inflight;
    int                 accepted;
    int                 blocked;
    int                 mismatches;
    int                 protocol;
    int                 cycles;
    int                 pause_left;

    exec_cluster DUT (.*);

    exec_cluster_checks checks (.*, .fails(port_fails));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rename snoops the bus so it knows which results already went out
    always @(posedge clk) begin
        if (rst && DUT.cdb.valid) begin
            done_model[DUT.cdb.tag] = 1'b1;
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic exec_pkg::word_t expected_result(
        input exec_pkg::op_t   code,
        input exec_pkg::word_t a,
        input exec_pkg::word_t b
    );
        logic [4:0] s;
        logic       lt_s;
        logic       lt_u;
        s    = b[4:0];
        lt_u = a < b;
        // flipping the sign bits turns a signed compare into an unsigned one
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (code)
            exec_pkg::op_add, exec_pkg::op_jalr: return a + b;
            exec_pkg::op_sub:                    return a - b;
            exec_pkg::op_and:                    return a & b;
            exec_pkg::op_or:                     return a | b;
            exec_pkg::op_xor:                    return a ^ b;
            exec_pkg::op_sll:                    return a << s;
            exec_pkg::op_srl:                    return a >> s;
            exec_pkg::op_sra:  return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            exec_pkg::op_slt, exec_pkg::op_lt:   return 32'(lt_s);
            exec_pkg::op_sltu, exec_pkg::op_ltu: return 32'(lt_u);
            exec_pkg::op_ge:                     return 32'(!lt_s);
            exec_pkg::op_geu:                    return 32'(!lt_u);
            exec_pkg::op_eq:                     return 32'(a == b);
            exec_pkg::op_ne:                     return 32'(a != b);
            default:                             return 32'h0;
        endcase
    endfunction

    task automatic pick_operand(
        output exec_pkg::operand_t opnd,
        output exec_pkg::word_t    value,
        input  exec_pkg::word_t    other
    );
        logic [1:0]     mode;
        exec_pkg::tag_t t;
        mode       = take_bits(2);
        opnd.tag   = take_bits(3);
        opnd.ready = 1'b1;
        if (mode[1] && inflight > 0) begin
            // depend on an older uncommitted operation
            t          = head_tag + take_bits(3) % inflight;
            value      = gold[t];
            opnd.tag   = t;
            opnd.ready = done_model[t];
        end else if (mode[0]) begin
            value = take_bits(1) ? other : take_bits(6);
        end else begin
            value = take_bits(32);
        end
        opnd.value = opnd.ready ? value : take_bits(32);
    endtask

    task automatic compare_commit();
        if (commit_valid) begin
            assert (inflight > 0) else begin
                protocol++;
                $display("commit seen with nothing in flight at %0t", $time);
            end
            assert (commit_tag == head_tag) else begin
                mismatches++;
                $display("mismatch at %0t: commit tag %0d, expected %0d",
                         $time, commit_tag, head_tag);
            end
            assert (commit_value == gold[head_tag]) else begin
                mismatches++;
                $display("mismatch at %0t: tag %0d value %h, expected %h",
                         $time, head_tag, commit_value, gold[head_tag]);
            end
            assert (commit_is_branch == gbr[head_tag]) else begin
                mismatches++;
                $display("mismatch at %0t: tag %0d branch flag wrong", $time, head_tag);
            end
            head_tag = head_tag + 1'b1;
            inflight = inflight - 1;
        end
    endtask

    task automatic watch_ready();
        exec_pkg::tag_t t;
        int             pending;
        pending = 0;
        for (int i = 0; i < inflight; i++) begin
            t = head_tag + i;
            if (!done_model[t]) begin
                pending++;
            end
        end
        assert (dispatch_tag == tail_tag) else begin
            mismatches++;
            $display("mismatch at %0t: dispatch tag %0d, expected %0d",
                     $time, dispatch_tag, tail_tag);
        end
        assert (!(dispatch_ready && inflight == exec_pkg::rob_depth)) else begin
            protocol++;
            $display("dispatch_ready stayed high with the ROB full at %0t", $time);
        end
        assert (dispatch_ready || inflight == exec_pkg::rob_depth ||
                pending >= exec_pkg::rs_depth) else begin
            protocol++;
            $display("dispatch_ready fell with room in ROB and station at %0t", $time);
        end
        if (!dispatch_ready) begin
            blocked++;
        end
    endtask

    task automatic dispatch_one();
        exec_pkg::word_t g1;
        exec_pkg::word_t g2;
        if (dispatch_ready) begin
            op        = take_bits(5);
            is_branch = take_bits(1);
            pick_operand(src_1, g1, take_bits(32));
            pick_operand(src_2, g2, g1);
            gold[tail_tag]       = expected_result(op, g1, g2);
            gbr[tail_tag]        = is_branch;
            done_model[tail_tag] = 1'b0;
            tail_tag             = tail_tag + 1'b1;
            inflight++;
            accepted++;
            dispatch = 1'b1;
        end else begin
            // a strobe while blocked must be dropped
            dispatch = take_bits(1);
            op       = take_bits(5);
        end
    endtask

    task automatic step(input logic want, input logic hold);
        @(negedge clk);
        compare_commit();
        watch_ready();
        pause = hold;
        if (want) begin
            dispatch_one();
        end else begin
            dispatch = 1'b0;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        pause      = 1'b0;
        dispatch   = 1'b0;
        is_branch  = 1'b0;
        op         = '0;
        src_1      = '0;
        src_2      = '0;
        lfsr       = 32'h9778_da7d;
        head_tag   = '0;
        tail_tag   = '0;
        inflight   = 0;
        accepted   = 0;
        blocked    = 0;
        mismatches = 0;
        protocol   = 0;
        pause_left = 0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        assert (dispatch_ready && !commit_valid && dispatch_tag == '0) else begin
            protocol++;
            $display("cluster was not idle with tag 0 after reset");
        end
        // random traffic with pause windows
        while (accepted < n_random) begin
            if (pause_left > 0) begin
                pause_left--;
            end else if (take_bits(4) == 0) begin
                pause_left = 1 + take_bits(4);
            end
            step(take_bits(2) != 0, pause_left > 0);
        end
        // hold the back end so the station fills up
        blocked = 0;
        repeat (n_burst) step(1'b1, 1'b1);
        assert (blocked > 0) else begin
            protocol++;
            $display("dispatch_ready never fell while the station was held");
        end
        while (inflight > 0) step(1'b0, 1'b0);
        repeat (8) step(1'b0, 1'b0);
        $display("errors: %0d value mismatches, %0d protocol failures, %0d port check failures",
                 mismatches, protocol, port_fails);
        if (mismatches + protocol + port_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/exec_pkg.sv
source/cdb_if.sv
source/alu_unit.sv
source/alu_station.sv
source/reorder_buffer.sv
source/exec_cluster.sv
bench/exec_cluster_checks.sv
bench/exec_cluster_tb.sv

// File: source/alu_station.sv
// four-entry reservation station, holds dispatched ALU operations until both operands are known
module alu_station (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pause,
    input  logic                 rob_full,
    input  logic                 dispatch,
    input  exec_pkg::op_t        dispatch_op,
    input  logic                 dispatch_is_branch,
    input  exec_pkg::tag_t       dispatch_tag,
    input  exec_pkg::operand_t   src_1,
    input  exec_pkg::operand_t   src_2,
    output logic                 dispatch_ready,
    output logic                 issue,
    output exec_pkg::op_t        issue_op,
    output logic                 issue_is_branch,
    output exec_pkg::tag_t       issue_tag,
    output exec_pkg::word_t      issue_value_1,
    output exec_pkg::word_t      issue_value_2,
    cdb_if.listener              cdb
);

    logic [exec_pkg::rs_depth-1:0] busy;
    logic [exec_pkg::rs_depth-1:0] rdy;
    logic [exec_pkg::rs_depth-1:0] issue_sel;
    logic [exec_pkg::rs_depth-1:0] free_sel;
    logic [exec_pkg::rs_depth-1:0] alloc_sel;
    logic                          accept;

    exec_pkg::op_t      op_q   [exec_pkg::rs_depth];
    logic               br_q   [exec_pkg::rs_depth];
    exec_pkg::tag_t     tag_q  [exec_pkg::rs_depth];
    exec_pkg::operand_t src1_q [exec_pkg::rs_depth];
    exec_pkg::operand_t src2_q [exec_pkg::rs_depth];

    // fill a waiting operand when its producer is on the bus
    function automatic exec_pkg::operand_t snoop(
        input exec_pkg::operand_t opnd,
        input logic               bus_valid,
        input exec_pkg::tag_t     bus_tag,
        input exec_pkg::word_t    bus_value
    );
        exec_pkg::operand_t r;
        r = opnd;
        if (!opnd.ready && bus_valid && opnd.tag == bus_tag) begin
            r.ready = 1'b1;
            r.value = bus_value;
        end
        return r;
    endfunction

    // lowest ready entry issues, lowest free entry takes the next dispatch
    always_comb begin
        issue_sel = '0;
        free_sel  = '0;
        for (int i = exec_pkg::rs_depth - 1; i >= 0; i--) begin
            rdy[i] = busy[i] & src1_q[i].ready & src2_q[i].ready;
            if (rdy[i]) begin
                issue_sel    = '0;
                issue_sel[i] = 1'b1;
            end
            if (!busy[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    assign dispatch_ready = !rob_full && !(&busy);
    assign accept         = dispatch && dispatch_ready;
    assign alloc_sel      = accept ? free_sel : '0;
    assign issue          = (|rdy) && !pause;

    always_comb begin
        issue_op        = '0;
        issue_is_branch = 1'b0;
        issue_tag       = '0;
        issue_value_1   = '0;
        issue_value_2   = '0;
        for (int i = 0; i < exec_pkg::rs_depth; i++) begin
            if (issue_sel[i]) begin
                issue_op        = op_q[i];
                issue_is_branch = br_q[i];
                issue_tag       = tag_q[i];
                issue_value_1   = src1_q[i].value;
                issue_value_2   = src2_q[i].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < exec_pkg::rs_depth; i++) begin
                if (alloc_sel[i]) begin
                    busy[i] <= 1'b1;
                end else if (issue && issue_sel[i]) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    // the bus is checked even on the write edge so no broadcast slips by
    always_ff @(posedge clk) begin
        for (int i = 0; i < exec_pkg::rs_depth; i++) begin
            if (alloc_sel[i]) begin
                op_q[i]   <= dispatch_op;
                br_q[i]   <= dispatch_is_branch;
                tag_q[i]  <= dispatch_tag;
                src1_q[i] <= snoop(src_1, cdb.valid, cdb.tag, cdb.value);
                src2_q[i] <= snoop(src_2, cdb.valid, cdb.tag, cdb.value);
            end else begin
                src1_q[i] <= snoop(src1_q[i], cdb.valid, cdb.tag, cdb.value);
                src2_q[i] <= snoop(src2_q[i], cdb.valid, cdb.tag, cdb.value);
            end
        end
    end

endmodule

// File: source/alu_unit.sv
// single-stage ALU, registers one issued operation per cycle and broadcasts it on the data bus
module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              pause,
    input  logic              issue,
    input  exec_pkg::op_t     op,
    input  logic              is_branch,
    input  exec_pkg::tag_t    tag,
    input  exec_pkg::word_t   value_1,
    input  exec_pkg::word_t   value_2,
    cdb_if.broadcaster        cdb
);

    exec_pkg::word_t result;
    logic [4:0]      shamt;

    logic            valid_q;
    exec_pkg::tag_t  tag_q;
    exec_pkg::word_t value_q;
    logic            br_q;

    assign shamt = value_2[4:0];

    always_comb begin
        case (op)
            exec_pkg::op_add:  result = value_1 + value_2;
            exec_pkg::op_jalr: result = value_1 + value_2;
            exec_pkg::op_sub:  result = value_1 - value_2;
            exec_pkg::op_and:  result = value_1 & value_2;
            exec_pkg::op_or:   result = value_1 | value_2;
            exec_pkg::op_xor:  result = value_1 ^ value_2;
            exec_pkg::op_sll:  result = value_1 << shamt;
            exec_pkg::op_srl:  result = value_1 >> shamt;
            exec_pkg::op_sra:  result = $unsigned($signed(value_1) >>> shamt);
            exec_pkg::op_slt:  result = {31'd0, $signed(value_1) < $signed(value_2)};
            exec_pkg::op_lt:   result = {31'd0, $signed(value_1) < $signed(value_2)};
            exec_pkg::op_sltu: result = {31'd0, value_1 < value_2};
            exec_pkg::op_ltu:  result = {31'd0, value_1 < value_2};
            exec_pkg::op_ge:   result = {31'd0, $signed(value_1) >= $signed(value_2)};
            exec_pkg::op_geu:  result = {31'd0, value_1 >= value_2};
            exec_pkg::op_eq:   result = {31'd0, value_1 == value_2};
            exec_pkg::op_ne:   result = {31'd0, value_1 != value_2};
            default:           result = '0;
        endcase
    end

    // pause freezes the whole output stage, a pending result waits in it
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (!pause) begin
            valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause && issue) begin
            tag_q   <= tag;
            value_q <= result;
            br_q    <= is_branch;
        end
    end

    // a held result goes out once pause drops
    assign cdb.valid     = valid_q & ~pause;
    assign cdb.tag       = tag_q;
    assign cdb.value     = value_q;
    assign cdb.is_branch = br_q;

    // an issue during pause would be dropped by the frozen stage
    a_quiet_in_pause: assert property (
        @(posedge clk) disable iff (!rst)
        pause |-> !issue
    ) else $error("ALU received an issue during pause");

endmodule

// File: source/cdb_if.sv
// common data bus between the ALU and the units that wait on its results
interface cdb_if (
    input logic clk,
    input logic rst
);

    logic              valid;
    exec_pkg::tag_t    tag;
    exec_pkg::word_t   value;
    logic              is_branch;

    // the ALU drives results
    modport broadcaster (
        input  clk, rst,
        output valid, tag, value, is_branch
    );

    // station and ROB snoop results
    modport listener (
        input  clk, rst, valid, tag, value, is_branch
    );

endinterface

// File: source/exec_cluster.sv
// integer execution cluster top, takes dispatches from rename and returns in-order commits
module exec_cluster (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pause,
    input  logic                 dispatch,
    input  exec_pkg::op_t        op,
    input  logic                 is_branch,
    input  exec_pkg::operand_t   src_1,
    input  exec_pkg::operand_t   src_2,
    output logic                 dispatch_ready,
    output exec_pkg::tag_t       dispatch_tag,
    output logic                 commit_valid,
    output exec_pkg::tag_t       commit_tag,
    output exec_pkg::word_t      commit_value,
    output logic                 commit_is_branch
);

    logic            rob_full;
    logic            allocate;
    logic            issue;
    exec_pkg::op_t   issue_op;
    logic            issue_is_branch;
    exec_pkg::tag_t  issue_tag;
    exec_pkg::word_t issue_value_1;
    exec_pkg::word_t issue_value_2;

    cdb_if cdb (.clk(clk), .rst(rst));

    // accepted dispatch takes the current tail tag
    assign allocate = dispatch & dispatch_ready;

    alu_station u_station (
        .clk                (clk),
        .rst                (rst),
        .pause              (pause),
        .rob_full           (rob_full),
        .dispatch           (dispatch),
        .dispatch_op        (op),
        .dispatch_is_branch (is_branch),
        .dispatch_tag       (dispatch_tag),
        .src_1              (src_1),
        .src_2              (src_2),
        .dispatch_ready     (dispatch_ready),
        .issue              (issue),
        .issue_op           (issue_op),
        .issue_is_branch    (issue_is_branch),
        .issue_tag          (issue_tag),
        .issue_value_1      (issue_value_1),
        .issue_value_2      (issue_value_2),
        .cdb                (cdb.listener)
    );

    alu_unit u_alu (
        .clk       (clk),
        .rst       (rst),
        .pause     (pause),
        .issue     (issue),
        .op        (issue_op),
        .is_branch (issue_is_branch),
        .tag       (issue_tag),
        .value_1   (issue_value_1),
        .value_2   (issue_value_2),
        .cdb       (cdb.broadcaster)
    );

    reorder_buffer u_rob (
        .clk              (clk),
        .rst              (rst),
        .allocate         (allocate),
        .tail             (dispatch_tag),
        .rob_full         (rob_full),
        .commit_valid     (commit_valid),
        .commit_tag       (commit_tag),
        .commit_value     (commit_value),
        .commit_is_branch (commit_is_branch),
        .cdb              (cdb.listener)
    );

endmodule

// File: source/exec_pkg.sv
// shared types, sizes and ALU opcodes of the execution cluster, referenced as exec_pkg::name
package exec_pkg;

    // entry counts are tied to the tag width
    localparam int tag_w = 3;
    localparam int rob_depth = 8;
    localparam int rs_depth = 4;

    typedef logic [31:0] word_t;
    typedef logic [tag_w-1:0] tag_t;
    typedef logic [4:0] op_t;

    // opcode encodings, unlisted codes give 0
    localparam op_t op_add  = 5'b00000;
    localparam op_t op_and  = 5'b00001;
    localparam op_t op_or   = 5'b00010;
    localparam op_t op_sll  = 5'b00011;
    localparam op_t op_srl  = 5'b00100;
    localparam op_t op_slt  = 5'b00101;
    localparam op_t op_sltu = 5'b00110;
    localparam op_t op_sra  = 5'b00111;
    localparam op_t op_sub  = 5'b01000;
    localparam op_t op_xor  = 5'b01001;
    localparam op_t op_eq   = 5'b01010;
    localparam op_t op_ge   = 5'b01011;
    localparam op_t op_ne   = 5'b01100;
    localparam op_t op_geu  = 5'b01101;
    localparam op_t op_jalr = 5'b10001;
    localparam op_t op_lt   = 5'b11010;
    localparam op_t op_ltu  = 5'b11011;

    // an operand is either a value or the tag of the ROB entry producing it
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t value;
    } operand_t;

endpackage

// File: source/reorder_buffer.sv
// eight-entry reorder buffer, hands out tags at dispatch and retires finished results in order
module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocate,
    output exec_pkg::tag_t    tail,
    output logic              rob_full,
    output logic              commit_valid,
    output exec_pkg::tag_t    commit_tag,
    output exec_pkg::word_t   commit_value,
    output logic              commit_is_branch,
    cdb_if.listener           cdb
);

    exec_pkg::tag_t                 head;
    logic [exec_pkg::tag_w:0]       count;
    logic [exec_pkg::rob_depth-1:0] done;
    logic [exec_pkg::rob_depth-1:0] br_q;
    exec_pkg::word_t                value_q [exec_pkg::rob_depth];

    logic           retire;
    exec_pkg::tag_t bus_dist;
    logic           bus_in_flight;

    assign rob_full = (count == exec_pkg::rob_depth);
    assign retire   = done[head];

    // entries from head up to count are allocated
    assign bus_dist      = cdb.tag - head;
    assign bus_in_flight = ({1'b0, bus_dist} < count);

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (allocate) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({allocate, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
            br_q[cdb.tag]    <= cdb.is_branch;
        end
        if (retire) begin
            commit_tag       <= head;
            commit_value     <= value_q[head];
            commit_is_branch <= br_q[head];
        end
    end

    // each result belongs to a live entry and arrives only once
    a_bus_hits_live_entry: assert property (
        @(posedge cdb.clk) disable iff (!cdb.rst)
        cdb.valid |-> (bus_in_flight && !done[cdb.tag])
    ) else $error("data bus marked a ROB entry that is not waiting for a result");

endmodule
